// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dmem_axi_tb -f src.f -Mdir obj_dir -o dmem_axi_sim
./obj_dir/dmem_axi_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

// ==== sim/dmem_axi_tb.sv ====
module dmem_axi_tb import dmem_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200;
    localparam int NUM_OPS = 300;

    logic              CLK = 1'b0;
    logic              RST;
    logic              rden;
    logic [ADDR_W-1:0] raddr;
    logic              wren;
    logic [ADDR_W-1:0] waddr;
    logic [STRB_W-1:0] wstrb;
    logic [DATA_W-1:0] wdata;
    logic              stall;
    logic              loading;
    logic              rvalid;
    logic [ADDR_W-1:0] roaddr;
    logic [DATA_W-1:0] rdata;

    logic [DATA_W-1:0] model_mem [RAM_WORDS];
    int                errors = 0;
    int                timeouts = 0;

    dmem_axi_top uut (
        .CLK     (CLK),
        .RST     (RST),
        .rden    (rden),
        .raddr   (raddr),
        .wren    (wren),
        .waddr   (waddr),
        .wstrb   (wstrb),
        .wdata   (wdata),
        .stall   (stall),
        .loading (loading),
        .rvalid  (rvalid),
        .roaddr  (roaddr),
        .rdata   (rdata)
    );

    always #5 CLK = ~CLK;

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0d ns: %s, got %h, expected %h",
                     $time, msg, actual, expected);
        end
    endtask

    function automatic logic [ADDR_W-1:0] word_addr(input int idx);
        return AXI_BASE + ADDR_W'(idx * 4);
    endfunction

    function automatic int word_index(input logic [ADDR_W-1:0] addr);
        return int'((addr - AXI_BASE) >> 2);
    endfunction

    // Mostly a small range so reads hit recent writes
    function automatic int pick_index();
        if ($urandom_range(0, 1) == 1) begin
            return int'($urandom_range(0, 15));
        end
        return int'($urandom_range(0, RAM_WORDS - 1));
    endfunction

    function automatic logic [ADDR_W-1:0] outside_addr(input int idx);
        if ($urandom_range(0, 1) == 1) begin
            return AXI_BASE + RAM_BYTES + ADDR_W'(idx * 4);
        end
        return AXI_BASE - RAM_BYTES + ADDR_W'(idx * 4);
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [STRB_W-1:0] pick_strb();
        if ($urandom_range(0, 2) == 0) begin
            return '1;
        end
        return STRB_W'($urandom);
    endfunction

    // Returns at the falling edge of the cycle in which loading drops
    task automatic wait_done(input string what, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < TIMEOUT) begin
            @(negedge CLK);
            if (!loading) begin
                ok = 1'b1;
            end else begin
                check(32'(rvalid), 32'd0, "rvalid low while loading");
                cycles++;
            end
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout: %s did not finish within %0d cycles at %0d ns",
                     what, TIMEOUT, $time);
        end
    endtask

    // Pulse checks after the edge where the enable was dropped
    task automatic check_completion(input logic [ADDR_W-1:0] addr,
                                    input logic [DATA_W-1:0] expected, input bit hold);
        int hold_cycles;
        hold_cycles = int'($urandom_range(1, 3));
        @(negedge CLK);
        check(32'(rvalid), 32'd1, "rvalid after read completion");
        check(roaddr, addr, "roaddr of completed read");
        check(rdata, expected, "read data");
        if (hold) begin
            repeat (hold_cycles) begin
                @(negedge CLK);
                check(32'(rvalid), 32'd1, "rvalid held during stall");
                check(rdata, expected, "rdata held during stall");
            end
            @(posedge CLK);
            stall <= 1'b0;
            // Stall is still sampled high at this edge
            @(negedge CLK);
            check(32'(rvalid), 32'd1, "rvalid in last stalled cycle");
        end
        @(negedge CLK);
        check(32'(rvalid), 32'd0, "rvalid is a single pulse");
    endtask

    task automatic do_read(input logic [ADDR_W-1:0] addr, input bit hold);
        logic [DATA_W-1:0] expected;
        bit                ok;
        expected = model_mem[word_index(addr)];
        @(posedge CLK);
        rden  <= 1'b1;
        raddr <= addr;
        stall <= hold;
        wait_done("read", ok);
        @(posedge CLK);
        rden <= 1'b0;
        if (ok) begin
            check_completion(addr, expected, hold);
        end
    endtask

    task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb);
        bit ok;
        @(posedge CLK);
        wren  <= 1'b1;
        waddr <= addr;
        wdata <= data;
        wstrb <= strb;
        wait_done("write", ok);
        @(posedge CLK);
        wren <= 1'b0;
        if (ok) begin
            model_mem[word_index(addr)] = merge_bytes(model_mem[word_index(addr)], data, strb);
            @(negedge CLK);
            check(32'(rvalid), 32'd0, "no read pulse after a write");
        end
    endtask

    // Read data is taken before the write lands, so the old word comes back
    task automatic do_read_write(input logic [ADDR_W-1:0] ra, input logic [ADDR_W-1:0] wa,
                                 input logic [DATA_W-1:0] data,
                                 input logic [STRB_W-1:0] strb, input bit hold);
        logic [DATA_W-1:0] expected;
        bit                ok;
        expected = model_mem[word_index(ra)];
        @(posedge CLK);
        rden  <= 1'b1;
        raddr <= ra;
        wren  <= 1'b1;
        waddr <= wa;
        wdata <= data;
        wstrb <= strb;
        stall <= hold;
        wait_done("concurrent read and write", ok);
        @(posedge CLK);
        rden <= 1'b0;
        wren <= 1'b0;
        if (ok) begin
            model_mem[word_index(wa)] = merge_bytes(model_mem[word_index(wa)], data, strb);
            check_completion(ra, expected, hold);
        end
    endtask

    task automatic do_outside(input int kind, input int idx);
        @(posedge CLK);
        rden  <= (kind != 1);
        raddr <= outside_addr(idx);
        wren  <= (kind != 0);
        waddr <= outside_addr(idx);
        wdata <= $urandom;
        wstrb <= pick_strb();
        stall <= 1'b0;
        repeat (10) begin
            @(negedge CLK);
            check(32'(loading), 32'd0, "loading low for out-of-window access");
            check(32'(rvalid), 32'd0, "rvalid low for out-of-window access");
        end
        @(posedge CLK);
        rden <= 1'b0;
        wren <= 1'b0;
    endtask

    initial begin
        int               op;
        int               idx;
        int               idx2;
        logic [ADDR_W-1:0] addr;
        void'($urandom(32'h432));
        RST   <= 1'b1;
        rden  <= 1'b0;
        raddr <= '0;
        wren  <= 1'b0;
        waddr <= '0;
        wstrb <= '0;
        wdata <= '0;
        stall <= 1'b0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (2) @(posedge CLK);
        RST <= 1'b0;

        for (int n = 0; n < NUM_OPS && timeouts == 0; n++) begin
            op = int'($urandom_range(0, 3));
            idx = pick_index();
            addr = word_addr(idx);
            case (op)
                0: begin
                    do_read(addr, $urandom_range(0, 2) == 0);
                end
                1: begin
                    do_write(addr, $urandom, pick_strb());
                    do_read(addr, $urandom_range(0, 2) == 0);
                end
                2: begin
                    idx2 = pick_index();
                    do_read_write(word_addr(idx2), addr, $urandom, pick_strb(),
                                  $urandom_range(0, 2) == 0);
                    do_read(addr, 1'b0);
                end
                default: begin
                    do_outside(int'($urandom_range(0, 2)), idx);
                    // The word an aliasing slave would hit must be untouched
                    do_read(addr, 1'b0);
                end
            endcase
        end

        repeat (2) @(posedge CLK);
        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
verilog/dmem_pkg.sv
verilog/dmem_request_decode.sv
verilog/translate_axi.sv
verilog/axi_ram_slave.sv
verilog/dmem_axi_top.sv
sim/dmem_axi_tb.sv

// ==== verilog/axi_ram_slave.sv ====
module axi_ram_slave import dmem_pkg::*; (
    input  logic    CLK,
    input  logic    RST,
    input  axi_ax_t aw,
    input  axi_w_t  w,
    input  axi_ax_t ar,
    output logic    awready,
    output logic    wready,
    output logic    arready,
    output axi_r_t  r,
    output axi_b_t  b
);

    logic [DATA_W-1:0]    mem [RAM_WORDS];
    logic [ADDR_W-1:0]    ar_off;
    logic [ADDR_W-1:0]    aw_off;
    logic                 rd_busy;
    logic [WAIT_W-1:0]    rd_cnt;
    logic [RAM_IDX_W-1:0] rd_idx;
    logic                 wr_busy;
    logic [WAIT_W-1:0]    wr_cnt;
    logic [RAM_IDX_W-1:0] wr_idx;

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign ar_off = ar.addr - AXI_BASE;
    assign aw_off = aw.addr - AXI_BASE;

    // Read side, R pulses RAM_WAIT cycles after the AR handshake
    always_ff @(posedge CLK) begin
        if (RST) begin
            arready <= 1'b0;
            rd_busy <= 1'b0;
            r.valid <= 1'b0;
        end else begin
            r.valid <= 1'b0;
            if (arready && ar.valid) begin
                arready <= 1'b0;
                rd_busy <= 1'b1;
                rd_cnt  <= WAIT_W'(RAM_WAIT);
                rd_idx  <= ar_off[RAM_IDX_W+1:2];
            end else if (!rd_busy && ar.valid) begin
                arready <= 1'b1;
            end else if (rd_busy) begin
                if (rd_cnt == WAIT_W'(1)) begin
                    rd_busy <= 1'b0;
                    r <= '{data: mem[rd_idx], resp: AXI_RESP_OKAY, last: 1'b1, valid: 1'b1};
                end else begin
                    rd_cnt <= rd_cnt - WAIT_W'(1);
                end
            end
        end
    end

    // Write side, WREADY after the wait, B one cycle after the W beat
    always_ff @(posedge CLK) begin
        if (RST) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            wr_busy <= 1'b0;
            b.valid <= 1'b0;
        end else begin
            b.valid <= 1'b0;
            if (awready && aw.valid) begin
                awready <= 1'b0;
                wr_busy <= 1'b1;
                wr_cnt  <= WAIT_W'(RAM_WAIT);
                wr_idx  <= aw_off[RAM_IDX_W+1:2];
            end else if (!wr_busy && aw.valid) begin
                awready <= 1'b1;
            end else if (wready && w.valid) begin
                wready  <= 1'b0;
                wr_busy <= 1'b0;
                b <= '{resp: AXI_RESP_OKAY, valid: 1'b1};
            end else if (wr_busy && !wready) begin
                if (wr_cnt == WAIT_W'(1)) begin
                    wready <= 1'b1;
                end else begin
                    wr_cnt <= wr_cnt - WAIT_W'(1);
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wready && w.valid) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    // Only single-beat bursts are served
    a_ar_len: assert property (@(posedge CLK) disable iff (RST)
        ar.valid && arready |-> ar.len == 8'd0);

    a_aw_len: assert property (@(posedge CLK) disable iff (RST)
        aw.valid && awready |-> aw.len == 8'd0);

endmodule

// ==== verilog/dmem_axi_top.sv ====
module dmem_axi_top import dmem_pkg::*; (
    input  logic              CLK,
    input  logic              RST,
    input  logic              rden,
    input  logic [ADDR_W-1:0] raddr,
    input  logic              wren,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [STRB_W-1:0] wstrb,
    input  logic [DATA_W-1:0] wdata,
    input  logic              stall,
    output logic              loading,
    output logic              rvalid,
    output logic [ADDR_W-1:0] roaddr,
    output logic [DATA_W-1:0] rdata
);

    rd_req_t rd_req;
    wr_req_t wr_req;
    axi_ax_t aw;
    axi_ax_t ar;
    axi_w_t  w;
    axi_r_t  r;
    axi_b_t  b;
    logic    awready;
    logic    wready;
    logic    arready;

    dmem_request_decode u_decode (
        .CLK     (CLK),
        .RST     (RST),
        .rden    (rden),
        .raddr   (raddr),
        .wren    (wren),
        .waddr   (waddr),
        .wstrb   (wstrb),
        .wdata   (wdata),
        .loading (loading),
        .rd_req  (rd_req),
        .wr_req  (wr_req)
    );

    translate_axi u_translate (
        .CLK     (CLK),
        .RST     (RST),
        .stall   (stall),
        .rd_req  (rd_req),
        .wr_req  (wr_req),
        .awready (awready),
        .wready  (wready),
        .arready (arready),
        .r       (r),
        .b       (b),
        .loading (loading),
        .roaddr  (roaddr),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .aw      (aw),
        .w       (w),
        .ar      (ar)
    );

    axi_ram_slave u_ram (
        .CLK     (CLK),
        .RST     (RST),
        .aw      (aw),
        .w       (w),
        .ar      (ar),
        .awready (awready),
        .wready  (wready),
        .arready (arready),
        .r       (r),
        .b       (b)
    );

endmodule

// ==== verilog/dmem_pkg.sv ====
package dmem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Window routed to the AXI bus
    localparam logic [ADDR_W-1:0] AXI_BASE = 32'h8000_0000;

    localparam int RAM_WORDS = 256;
    localparam logic [ADDR_W-1:0] RAM_BYTES = ADDR_W'(RAM_WORDS * STRB_W);
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);

    // Slave latency after an address handshake, at least 1
    localparam int RAM_WAIT = 2;
    localparam int WAIT_W = $clog2(RAM_WAIT + 1);

    localparam logic [2:0] AXI_SIZE_WORD = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] data;
    } wr_req_t;

    // AW and AR share one layout
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic              valid;
    } axi_ax_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
        logic              valid;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
        logic              valid;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
        logic       valid;
    } axi_b_t;

endpackage

// ==== verilog/dmem_request_decode.sv ====
module dmem_request_decode import dmem_pkg::*; (
    input  logic              CLK,
    input  logic              RST,
    input  logic              rden,
    input  logic [ADDR_W-1:0] raddr,
    input  logic              wren,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [STRB_W-1:0] wstrb,
    input  logic [DATA_W-1:0] wdata,
    input  logic              loading,
    output rd_req_t           rd_req,
    output wr_req_t           wr_req
);

    logic rd_hit;
    logic wr_hit;

    function automatic logic in_window(input logic [ADDR_W-1:0] addr);
        return (addr >= AXI_BASE) && ((addr - AXI_BASE) < RAM_BYTES);
    endfunction

    assign rd_hit = in_window(raddr);
    assign wr_hit = in_window(waddr);

    // Accesses outside the window never reach the translator
    assign rd_req = '{en: rden && rd_hit, addr: raddr};
    assign wr_req = '{
        en:   wren && wr_hit,
        addr: waddr,
        strb: wstrb,
        data: wdata
    };

    // CPU must hold a pending request until the translator lets go
    a_rd_hold: assert property (@(posedge CLK) disable iff (RST)
        rd_req.en && loading |=> rden && $stable(raddr));

    a_wr_hold: assert property (@(posedge CLK) disable iff (RST)
        wr_req.en && loading |=> wren && $stable({waddr, wstrb, wdata}));

    // Single-word bus, so sub-word addresses are a CPU fault
    a_rd_align: assert property (@(posedge CLK) disable iff (RST)
        rd_req.en |-> rd_req.addr[1:0] == 2'b00);

    a_wr_align: assert property (@(posedge CLK) disable iff (RST)
        wr_req.en |-> wr_req.addr[1:0] == 2'b00);

endmodule

// ==== verilog/translate_axi.sv ====
module translate_axi import dmem_pkg::*; (
    input  logic              CLK,
    input  logic              RST,
    input  logic              stall,
    input  rd_req_t           rd_req,
    input  wr_req_t           wr_req,
    input  logic              awready,
    input  logic              wready,
    input  logic              arready,
    input  axi_r_t            r,
    input  axi_b_t            b,
    output logic              loading,
    output logic [ADDR_W-1:0] roaddr,
    output logic              rvalid,
    output logic [DATA_W-1:0] rdata,
    output axi_ax_t           aw,
    output axi_w_t            w,
    output axi_ax_t           ar
);

    typedef enum logic [1:0] {
        SR_IDLE   = 2'b00,
        SR_ADDR   = 2'b01,
        SR_WAIT   = 2'b11,
        SR_FINISH = 2'b10
    } sr_state_t;

    typedef enum logic [1:0] {
        SW_IDLE   = 2'b00,
        SW_ADDR   = 2'b01,
        SW_WRITE  = 2'b11,
        SW_FINISH = 2'b10
    } sw_state_t;

    sr_state_t         sr_state;
    sr_state_t         sr_next;
    sw_state_t         sw_state;
    sw_state_t         sw_next;
    logic [DATA_W-1:0] rdata_cache;

    // Held high until a machine heads back to IDLE
    assign loading = (rd_req.en && sr_next != SR_IDLE) ||
                     (wr_req.en && sw_next != SW_IDLE);

    always_ff @(posedge CLK) begin
        if (RST) begin
            sr_state <= SR_IDLE;
            sw_state <= SW_IDLE;
        end else begin
            sr_state <= sr_next;
            sw_state <= sw_next;
        end
    end

    always_comb begin
        sr_next = sr_state;
        unique case (sr_state)
            SR_IDLE: begin
                if (rd_req.en) begin
                    sr_next = SR_ADDR;
                end
            end
            SR_ADDR: begin
                if (arready) begin
                    sr_next = SR_WAIT;
                end
            end
            SR_WAIT: begin
                if (r.valid) begin
                    sr_next = SR_FINISH;
                end
            end
            SR_FINISH: begin
                // Leave together with a concurrent write
                if (!wr_req.en || sw_state == SW_FINISH) begin
                    sr_next = SR_IDLE;
                end
            end
        endcase
    end

    always_comb begin
        sw_next = sw_state;
        unique case (sw_state)
            SW_IDLE: begin
                if (wr_req.en) begin
                    sw_next = SW_ADDR;
                end
            end
            SW_ADDR: begin
                if (awready) begin
                    sw_next = SW_WRITE;
                end
            end
            SW_WRITE: begin
                if (wready) begin
                    sw_next = SW_FINISH;
                end
            end
            SW_FINISH: begin
                if (!rd_req.en || sr_state == SR_FINISH) begin
                    sw_next = SW_IDLE;
                end
            end
        endcase
    end

    // AR channel
    always_ff @(posedge CLK) begin
        if (RST) begin
            ar.valid <= 1'b0;
        end else if (sr_next == SR_ADDR) begin
            ar <= '{
                addr:  rd_req.addr,
                len:   8'd0,
                size:  AXI_SIZE_WORD,
                burst: AXI_BURST_INCR,
                valid: 1'b1
            };
        end else if (sr_state == SR_ADDR && arready) begin
            ar.valid <= 1'b0;
        end
    end

    // No RREADY, so R is taken the cycle it shows up
    always_ff @(posedge CLK) begin
        if (sr_state == SR_WAIT && r.valid) begin
            rdata_cache <= r.data;
        end
    end

    // CPU side completion pulse, frozen while stalled
    always_ff @(posedge CLK) begin
        if (RST) begin
            roaddr <= '0;
            rvalid <= 1'b0;
            rdata  <= '0;
        end else if (rd_req.en && sr_next == SR_IDLE) begin
            roaddr <= rd_req.addr;
            rvalid <= 1'b1;
            rdata  <= rdata_cache;
        end else if (!stall) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end
    end

    // AW channel
    always_ff @(posedge CLK) begin
        if (RST) begin
            aw.valid <= 1'b0;
        end else if (sw_next == SW_ADDR) begin
            aw <= '{
                addr:  wr_req.addr,
                len:   8'd0,
                size:  AXI_SIZE_WORD,
                burst: AXI_BURST_INCR,
                valid: 1'b1
            };
        end else if (sw_state == SW_ADDR && awready) begin
            aw.valid <= 1'b0;
        end
    end

    // W channel rises with AW, single beat so last follows valid
    always_ff @(posedge CLK) begin
        if (RST) begin
            w.valid <= 1'b0;
            w.last  <= 1'b0;
        end else if (sw_next == SW_ADDR) begin
            w <= '{data: wr_req.data, strb: wr_req.strb, last: 1'b1, valid: 1'b1};
        end else if (sw_next == SW_FINISH) begin
            w.valid <= 1'b0;
            w.last  <= 1'b0;
        end
    end

    a_ar_hold: assert property (@(posedge CLK) disable iff (RST)
        ar.valid && !arready |=> ar.valid && $stable(ar.addr));

    a_aw_hold: assert property (@(posedge CLK) disable iff (RST)
        aw.valid && !awready |=> aw.valid && $stable(aw.addr));

    // The single W beat stays put until WREADY
    a_w_hold: assert property (@(posedge CLK) disable iff (RST)
        w.valid && !wready |=> w.valid && w.last && $stable({w.data, w.strb}));

    // B is not consumed, but it must land while the write is wrapping up
    a_b_timing: assert property (@(posedge CLK) disable iff (RST)
        b.valid |-> sw_state == SW_FINISH && b.resp == AXI_RESP_OKAY);

endmodule
